// File: Bender.yml
package:
  name: uart_cmd_port

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_pkg.sv
      - verilog/uart_tx.sv
      - verilog/uart_rx.sv
      - verilog/uart_cmd_ctrl.sv
      - verilog/uart_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/uart_chk.sv
      - verification/uart_tb.sv

// File: compile.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_cmd_ctrl.sv
verilog/uart_top.sv
verification/uart_chk.sv
verification/uart_tb.sv

// File: verification/uart_chk.sv
`timescale 1ns/1ps

module uart_chk (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_vld,
  input logic parity_err
);

  int unsigned err_cnt = 0;

  // a received frame is either good or bad
  a_rx_result_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_vld && parity_err))
    else begin
      $error("read_vld and parity_err high in the same cycle");
      err_cnt = err_cnt + 1;
    end

  // line is idle whenever no command is in flight
  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else begin
      $error("tx low while cmd_rdy is high");
      err_cnt = err_cnt + 1;
    end

  a_rdy_drop: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else begin
      $error("cmd_rdy still high after an accepted command");
      err_cnt = err_cnt + 1;
    end

endmodule

bind uart_top uart_chk u_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .cmd_vld    (cmd_vld),
  .cmd_rdy    (cmd_rdy),
  .tx         (tx),
  .read_vld   (read_vld),
  .parity_err (parity_err)
);

// File: verification/uart_tb.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tb;

  import uart_pkg::*;

  localparam int unsigned CLKS = `UART_CLKS_PER_BIT;

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  uart_byte_t read_data;
  logic       read_vld;
  logic       parity_err;

  logic [31:0] lcg_state;
  // {stop, parity, data} per frame seen on tx
  logic [9:0]  tx_frame_q[$];
  uart_byte_t  rx_byte_q[$];
  logic        rx_good_q[$];
  uart_byte_t  last_good;

  uart_top u_uart_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .rx         (rx),
    .tx         (tx),
    .read_data  (read_data),
    .read_vld   (read_vld),
    .parity_err (parity_err)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic stop_with_fail();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic raise_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    stop_with_fail();
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    stop_with_fail();
  endtask

  task automatic compare_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
    if (got !== exp)
      raise_mismatch($sformatf("%s got %02h expected %02h", what, got, exp));
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      raise_mismatch($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // parity bit that makes the nine bits hold an odd number of ones
  function automatic logic odd_parity(input uart_byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) ones += b[i];
    return (ones % 2 == 0);
  endfunction

  function automatic int expected_frames(input uart_cmd_t cmd, output uart_byte_t first,
                                         output uart_byte_t second);
    first  = cmd[15:8];
    second = cmd[7:0];
    return cmd[15] ? 2 : 1;
  endfunction

  // tx monitor, samples each bit at its centre
  initial begin : tx_monitor
    logic [9:0] frame;
    logic       tx_prev;
    tx_prev = 1'b1;
    forever begin
      @(posedge clk);
      if (tx_prev === 1'b1 && tx === 1'b0) begin
        repeat (CLKS / 2 - 1) @(posedge clk);
        for (int i = 0; i < 10; i++) begin
          repeat (CLKS) @(posedge clk);
          frame[i] = tx;
        end
        tx_frame_q.push_back(frame);
      end
      tx_prev = tx;
    end
  end

  // receive results against the frames sent on rx
  always @(posedge clk) begin : rx_compare
    uart_byte_t exp_b;
    logic       exp_good;
    if (rst_n === 1'b1 && (read_vld === 1'b1 || parity_err === 1'b1)) begin
      if (rx_byte_q.size() == 0) abort_run("receive result pulsed with no frame outstanding");
      exp_b    = rx_byte_q.pop_front();
      exp_good = rx_good_q.pop_front();
      compare_bit(read_vld, exp_good, "read_vld");
      compare_bit(parity_err, !exp_good, "parity_err");
      if (exp_good) last_good = exp_b;
      compare_byte(read_data, last_good, "read_data");
    end
  end

  always @(posedge clk) begin
    if (u_uart_top.u_chk.err_cnt != 0) abort_run("an assertion in uart_chk failed");
  end

  task automatic wait_cmd_rdy(input int unsigned limit);
    int unsigned n;
    n = 0;
    @(posedge clk);
    while (cmd_rdy !== 1'b1) begin
      if (n >= limit) abort_run("timeout waiting for cmd_rdy to return high");
      n++;
      @(posedge clk);
    end
  endtask

  task automatic check_frame(input uart_byte_t exp);
    logic [9:0] frame;
    frame = tx_frame_q.pop_front();
    compare_byte(frame[7:0], exp, "tx frame data");
    compare_bit(frame[8], odd_parity(exp), "tx frame parity");
    compare_bit(frame[9], 1'b1, "tx frame stop bit");
  endtask

  // stray cmd_vld while busy must not change the frames
  task automatic run_command(input uart_cmd_t cmd, input logic send_stray);
    uart_byte_t exp_first;
    uart_byte_t exp_second;
    int         n_frames;
    n_frames = expected_frames(cmd, exp_first, exp_second);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    compare_bit(cmd_rdy, 1'b1, "cmd_rdy at accept");
    cmd_vld <= 1'b0;
    if (send_stray) begin
      repeat (3) @(posedge clk);
      cmd_in  <= ~cmd;
      cmd_vld <= 1'b1;
      repeat (2) @(posedge clk);
      cmd_vld <= 1'b0;
    end
    wait_cmd_rdy(24 * CLKS + 8);
    if (tx_frame_q.size() != n_frames)
      raise_mismatch($sformatf("command %04h gave %0d frames, expected %0d",
                               cmd, tx_frame_q.size(), n_frames));
    check_frame(exp_first);
    if (n_frames == 2) check_frame(exp_second);
  endtask

  task automatic send_rx_frame(input uart_byte_t b, input logic par);
    logic [10:0] frame;
    int unsigned n;
    frame = {1'b1, par, b, 1'b0};
    rx_byte_q.push_back(b);
    rx_good_q.push_back(par == odd_parity(b));
    for (int i = 0; i < `UART_FRAME_BITS; i++) begin
      rx <= frame[i];
      repeat (CLKS) @(posedge clk);
    end
    n = 0;
    while (rx_byte_q.size() != 0) begin
      if (n >= 2 * CLKS) abort_run("timeout waiting for read_vld or parity_err");
      n++;
      @(posedge clk);
    end
  endtask

  initial begin
    uart_cmd_t  cmd;
    uart_byte_t b;
    lcg_state = 32'hdddf42e5;
    last_good = '0;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    compare_bit(tx, 1'b1, "tx after reset");
    compare_bit(cmd_rdy, 1'b1, "cmd_rdy after reset");
    compare_bit(read_vld, 1'b0, "read_vld after reset");
    compare_bit(parity_err, 1'b0, "parity_err after reset");
    for (int i = 0; i < 6; i++) begin
      cmd     = next_rand();
      cmd[15] = 1'b1;
      run_command(cmd, 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      cmd     = next_rand();
      cmd[15] = 1'b0;
      run_command(cmd, 1'b0);
    end
    cmd = next_rand() | 16'h8000;
    run_command(cmd, 1'b1);
    cmd = next_rand() & 16'h7fff;
    run_command(cmd, 1'b1);
    for (int i = 0; i < 8; i++) begin
      b = uart_byte_t'(next_rand() >> 8);
      send_rx_frame(b, odd_parity(b));
    end
    for (int i = 0; i < 2; i++) begin
      b = uart_byte_t'(next_rand() >> 8);
      send_rx_frame(b, !odd_parity(b));
    end
    b = uart_byte_t'(next_rand() >> 8);
    send_rx_frame(b, odd_parity(b));
    repeat (4) @(posedge clk);
    if (u_uart_top.u_chk.err_cnt != 0) begin
      abort_run("uart_chk reported assertion failures");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// File: verilog/uart_cmd_ctrl.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_cmd_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::uart_cmd_t  cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx_start,
  output uart_pkg::uart_byte_t tx_byte,
  input  logic                 tx_done
);

  import uart_pkg::*;

  uart_cmd_t cmd_q;
  logic      start_q;
  logic      second_q;
  logic      accept;
  logic      is_write;
  logic      next_byte;
  logic      last_done;

  assign accept   = cmd_vld && cmd_rdy;
  assign is_write = cmd_q[15];

  // write commands chain the data byte onto the first tx_done
  assign next_byte = tx_done && !second_q && is_write;
  assign last_done = tx_done && (second_q || !is_write);

  assign tx_start = start_q || next_byte;
  assign tx_byte  = (second_q || next_byte) ? cmd_q[7:0] : cmd_q[15:8];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_rdy  <= 1'b1;
      start_q  <= 1'b0;
      second_q <= 1'b0;
    end else begin
      start_q <= accept;
      if (accept) begin
        cmd_rdy  <= 1'b0;
        second_q <= 1'b0;
      end else if (last_done) begin
        cmd_rdy  <= 1'b1;
        second_q <= 1'b0;
      end else if (next_byte) begin
        second_q <= 1'b1;
      end
    end
  end

  // held for the whole command
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

endmodule

// File: verilog/uart_pkg.sv
package uart_pkg;

  // one serial payload byte
  typedef logic [7:0] uart_byte_t;

  // host command word
  // bit 15 write flag, bits 14..8 address, bits 7..0 write data
  typedef logic [15:0] uart_cmd_t;

  // bit position inside one serial frame
  typedef logic [3:0] uart_bit_cnt_t;

endpackage

// File: verilog/uart_rx.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output uart_pkg::uart_byte_t read_data,
  output logic                 read_vld,
  output logic                 parity_err
);

  import uart_pkg::*;

  localparam int unsigned CLKS  = `UART_CLKS_PER_BIT;
  localparam int unsigned CNT_W = $clog2(CLKS);
  localparam int unsigned SYNC  = `UART_SYNC_STAGES;
  localparam uart_bit_cnt_t PAR_BIT  = uart_bit_cnt_t'(`UART_FRAME_BITS - 2);
  localparam uart_bit_cnt_t STOP_BIT = uart_bit_cnt_t'(`UART_FRAME_BITS - 1);

  logic [SYNC-1:0]  sync_q;
  logic             rx_s;
  logic             rx_prev;
  logic             start_edge;
  logic             busy;
  logic [CNT_W-1:0] baud_cnt;
  uart_bit_cnt_t    bit_idx;
  uart_byte_t       data_sr;
  logic             par_acc;
  logic             sample;

  assign rx_s       = sync_q[SYNC-1];
  assign start_edge = rx_prev && !rx_s;
  assign sample     = busy && (baud_cnt == '0);

  // line idles high, so reset the synchronizer to ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q  <= '1;
      rx_prev <= 1'b1;
    end else begin
      sync_q  <= {sync_q[SYNC-2:0], rx};
      rx_prev <= rx_s;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      par_acc    <= 1'b0;
      read_vld   <= 1'b0;
      parity_err <= 1'b0;
      read_data  <= '0;
    end else begin
      read_vld   <= 1'b0;
      parity_err <= 1'b0;
      if (!busy) begin
        if (start_edge) begin
          // first sample lands mid start bit
          busy     <= 1'b1;
          baud_cnt <= CNT_W'(CLKS / 2 - 1);
          bit_idx  <= '0;
          par_acc  <= 1'b0;
        end
      end else if (sample) begin
        baud_cnt <= CNT_W'(CLKS - 1);
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == '0) begin
          // glitch, not a real start bit
          if (rx_s) busy <= 1'b0;
        end else if (bit_idx == STOP_BIT) begin
          busy <= 1'b0;
          if (rx_s) begin
            read_vld   <= par_acc;
            parity_err <= !par_acc;
            if (par_acc) read_data <= data_sr;
          end
        end else begin
          par_acc <= par_acc ^ rx_s;
        end
      end else begin
        baud_cnt <= baud_cnt - 1'b1;
      end
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk) begin
    if (sample && (bit_idx != '0) && (bit_idx < PAR_BIT)) begin
      data_sr <= {rx_s, data_sr[7:1]};
    end
  end

endmodule

// File: verilog/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// clock cycles per serial bit, 115200 baud at 50 MHz
`define UART_CLKS_PER_BIT 434

// flip-flops between the rx pin and the receiver logic
`define UART_SYNC_STAGES 3

// start, 8 data, parity, stop
`define UART_FRAME_BITS 11

`endif

// File: verilog/uart_top.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::uart_cmd_t  cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic                 rx,
  output logic                 tx,
  output uart_pkg::uart_byte_t read_data,
  output logic                 read_vld,
  output logic                 parity_err
);

  import uart_pkg::*;

  logic       tx_start;
  logic       tx_done;
  uart_byte_t tx_byte;

  uart_cmd_ctrl u_cmd_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  // receive path runs on its own
  uart_rx u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .read_data  (read_data),
    .read_vld   (read_vld),
    .parity_err (parity_err)
  );

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx_start,
  input  uart_pkg::uart_byte_t tx_byte,
  output logic                 tx,
  output logic                 tx_done
);

  import uart_pkg::*;

  localparam int unsigned CLKS  = `UART_CLKS_PER_BIT;
  localparam int unsigned CNT_W = $clog2(CLKS);
  localparam uart_bit_cnt_t LAST_BIT = uart_bit_cnt_t'(`UART_FRAME_BITS - 1);

  logic                        busy;
  logic [CNT_W-1:0]            baud_cnt;
  uart_bit_cnt_t               bit_idx;
  logic [`UART_FRAME_BITS-2:0] frame_sr;
  logic                        bit_end;

  // last cycle of the current bit time
  assign bit_end = busy && (baud_cnt == CNT_W'(CLKS - 1));
  assign tx_done = bit_end && (bit_idx == LAST_BIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end else if (tx_start) begin
      // start bit goes out right away
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b0;
    end else if (bit_end) begin
      baud_cnt <= '0;
      if (bit_idx == LAST_BIT) begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end else begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= frame_sr[0];
      end
    end else if (busy) begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // stop, odd parity, data lsb first
  always_ff @(posedge clk) begin
    if (tx_start) begin
      frame_sr <= {1'b1, ~^tx_byte, tx_byte};
    end else if (bit_end) begin
      frame_sr <= {1'b1, frame_sr[`UART_FRAME_BITS-2:1]};
    end
  end

endmodule
